// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "Test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
source/core_pkg.sv
source/hazard_detection_unit.sv
source/reservation_station.sv
source/reorder_buffer.sv
source/alu_unit.sv
source/mem_unit.sv
source/dispatch_core.sv
tb/core_checker.sv
tb/tb_top.sv

// ==== source/alu_unit.sv ====
`default_nettype none

module alu_unit #(
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    issue_valid,
    input  wire core_pkg::instr_t  issue_instr,
    input  wire                    written,
    output logic                   wr_valid,
    output core_pkg::result_t      result,
    output logic                   branch_written
);
    import core_pkg::*;

    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] value;
    logic                  taken;
    logic                  is_branch_q;

    assign a     = issue_instr.payload.alu.a;
    assign b     = issue_instr.payload.alu.b;
    assign taken = (issue_instr.op == BEQ) && (a == b);

    always_comb begin
        case (issue_instr.op)
            ADD:     value = a + b;
            SUB:     value = a - b;
            AND:     value = a & b;
            XOR:     value = a ^ b;
            BEQ:     value = {{(DATA_WIDTH - 1){1'b0}}, taken};
            default: value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_valid    <= 1'b0;
            is_branch_q <= 1'b0;
        end else if (issue_valid) begin
            wr_valid    <= 1'b1;
            is_branch_q <= (issue_instr.op == BEQ);
        end else if (written) begin
            wr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result <= '{issue_instr.tag, value, taken, issue_instr.payload.alu.target};
        end
    end

    // Releases the branch hold in the hazard unit
    assign branch_written = wr_valid & written & is_branch_q;

endmodule

`default_nettype wire

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int DATA_WIDTH    = 16;
    localparam int ROB_DEPTH     = 8;
    localparam int TAG_WIDTH     = $clog2(ROB_DEPTH);
    localparam int ADDR_WIDTH    = 4;
    localparam int PAYLOAD_WIDTH = 3 * DATA_WIDTH;

    typedef enum logic [2:0] {ADD, SUB, AND, XOR, BEQ, LOAD, STORE} op_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] target;
    } alu_fields_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]                          addr;
        logic [DATA_WIDTH-1:0]                          data;
        logic [PAYLOAD_WIDTH-ADDR_WIDTH-DATA_WIDTH-1:0] pad;
    } mem_fields_t;

    // Op selects the view
    typedef union packed {
        alu_fields_t alu;
        mem_fields_t mem;
    } payload_u;

    typedef struct packed {
        op_t                  op;
        payload_u             payload;
        logic [TAG_WIDTH-1:0] tag;
    } instr_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] value;
        logic                  taken;
        logic [DATA_WIDTH-1:0] target;
    } result_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        op_t                   op;
        logic [DATA_WIDTH-1:0] value;
    } commit_t;

endpackage

`default_nettype wire

// ==== source/dispatch_core.sv ====
`default_nettype none

module dispatch_core #(
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH,
    parameter int ROB_DEPTH  = core_pkg::ROB_DEPTH,
    parameter int RS_DEPTH   = 4
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire core_pkg::instr_t  in_instr,
    output logic                   in_ready,
    output logic                   commit_valid,
    output core_pkg::commit_t      commit,
    output logic                   redirect_valid,
    output logic [DATA_WIDTH-1:0]  redirect_target
);
    import core_pkg::*;

    logic                 rob_enable;
    logic                 rs_alu_enable;
    logic                 rs_ld_st_enable;
    logic                 rs_alu_exec_stall;
    logic                 rs_ld_exec_stall;
    logic                 rs_alu_full;
    logic                 rs_ld_st_full;
    logic                 rob_full;
    logic [TAG_WIDTH-1:0] tail_tag;
    logic [TAG_WIDTH-1:0] head_tag;
    instr_t               disp_instr;

    logic    alu_issue_valid;
    logic    ld_issue_valid;
    instr_t  alu_issue_instr;
    instr_t  ld_issue_instr;
    logic    alu_wr_valid;
    logic    alu_wr_written;
    logic    alu_branch_written;
    result_t alu_result;
    logic    lb_wr_valid;
    logic    lb_wr_written;
    result_t lb_result;
    logic    commit_wr_mem;
    logic    ex_rd_mem;

    // Tag comes from the ROB tail
    assign disp_instr = {in_instr.op, in_instr.payload, tail_tag};

    hazard_detection_unit u_hazard (
        .clock, .reset, .in_valid,
        .in_op              (in_instr.op),
        .rs_alu_full, .rs_ld_st_full, .rob_full,
        .commit_wr_mem, .ex_rd_mem, .alu_branch_written,
        .alu_wr_valid, .alu_wr_written, .lb_wr_valid, .lb_wr_written,
        .if_enable          (in_ready),
        .rob_enable, .rs_alu_enable, .rs_ld_st_enable,
        .rs_alu_exec_stall, .rs_ld_exec_stall
    );

    reservation_station #(.DEPTH(RS_DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_rs_alu (
        .clock, .reset,
        .enable      (rs_alu_enable),
        .in_instr    (disp_instr),
        .exec_stall  (rs_alu_exec_stall),
        .head_only   (1'b0),
        .head_tag,
        .full        (rs_alu_full),
        .issue_valid (alu_issue_valid),
        .issue_instr (alu_issue_instr)
    );

    reservation_station #(.DEPTH(RS_DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_rs_ld_st (
        .clock, .reset,
        .enable      (rs_ld_st_enable),
        .in_instr    (disp_instr),
        .exec_stall  (rs_ld_exec_stall),
        .head_only   (1'b1),
        .head_tag,
        .full        (rs_ld_st_full),
        .issue_valid (ld_issue_valid),
        .issue_instr (ld_issue_instr)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_rob (
        .clock, .reset,
        .enable (rob_enable),
        .op     (in_instr.op),
        .alu_result, .alu_wr_valid, .lb_result, .lb_wr_valid,
        .full   (rob_full),
        .tail_tag, .head_tag, .alu_wr_written, .lb_wr_written,
        .commit_valid, .commit, .commit_wr_mem,
        .redirect_valid, .redirect_target
    );

    alu_unit #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
        .clock, .reset,
        .issue_valid    (alu_issue_valid),
        .issue_instr    (alu_issue_instr),
        .written        (alu_wr_written),
        .wr_valid       (alu_wr_valid),
        .result         (alu_result),
        .branch_written (alu_branch_written)
    );

    mem_unit #(.DATA_WIDTH(DATA_WIDTH)) u_mem (
        .clock, .reset,
        .issue_valid (ld_issue_valid),
        .issue_instr (ld_issue_instr),
        .written     (lb_wr_written),
        .commit_wr_mem,
        .commit_addr (lb_result.target[ADDR_WIDTH-1:0]),
        .commit_data (commit.value),
        .wr_valid    (lb_wr_valid),
        .result      (lb_result),
        .ex_rd_mem
    );

endmodule

`default_nettype wire

// ==== source/hazard_detection_unit.sv ====
`default_nettype none

module hazard_detection_unit (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 in_valid,
    input  wire core_pkg::op_t  in_op,
    input  wire                 rs_alu_full,
    input  wire                 rs_ld_st_full,
    input  wire                 rob_full,
    input  wire                 commit_wr_mem,
    input  wire                 ex_rd_mem,
    input  wire                 alu_branch_written,
    input  wire                 alu_wr_valid,
    input  wire                 alu_wr_written,
    input  wire                 lb_wr_valid,
    input  wire                 lb_wr_written,
    output logic                if_enable,
    output logic                rob_enable,
    output logic                rs_alu_enable,
    output logic                rs_ld_st_enable,
    output logic                rs_alu_exec_stall,
    output logic                rs_ld_exec_stall
);
    import core_pkg::*;

    logic is_ld_st;
    logic dispatch_stall;
    logic mem_port_busy;
    logic branch_in_exec;

    assign is_ld_st = (in_op == LOAD) || (in_op == STORE);

    // ==============================
    // Dispatch
    // ==============================
    assign dispatch_stall = rob_full
        | (is_ld_st & rs_ld_st_full)
        | (~is_ld_st & rs_alu_full)
        | branch_in_exec;

    // Fetch shares the data memory port
    assign mem_port_busy = commit_wr_mem | ex_rd_mem;

    assign if_enable       = ~(dispatch_stall | mem_port_busy);
    assign rob_enable      = in_valid & if_enable;
    assign rs_alu_enable   = rob_enable & ~is_ld_st;
    assign rs_ld_st_enable = rob_enable & is_ld_st;

    // Unit holds a result the bus has not taken
    assign rs_alu_exec_stall = alu_wr_valid & ~alu_wr_written;
    assign rs_ld_exec_stall  = lb_wr_valid & ~lb_wr_written;

    // Only one branch in flight at a time
    always_ff @(posedge clock) begin
        if (reset) begin
            branch_in_exec <= 1'b0;
        end else if (rs_alu_enable && in_op == BEQ) begin
            branch_in_exec <= 1'b1;
        end else if (alu_branch_written) begin
            branch_in_exec <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_unit.sv ====
`default_nettype none

module mem_unit #(
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            issue_valid,
    input  wire core_pkg::instr_t          issue_instr,
    input  wire                            written,
    input  wire                            commit_wr_mem,
    input  wire [core_pkg::ADDR_WIDTH-1:0] commit_addr,
    input  wire [DATA_WIDTH-1:0]           commit_data,
    output logic                           wr_valid,
    output core_pkg::result_t              result,
    output logic                           ex_rd_mem
);
    import core_pkg::*;

    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] value;

    assign addr      = issue_instr.payload.mem.addr;
    assign ex_rd_mem = issue_valid && (issue_instr.op == LOAD);

    // Load reads now, store returns its own data
    assign value = (issue_instr.op == LOAD) ? mem[addr] : issue_instr.payload.mem.data;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (commit_wr_mem) begin
            mem[commit_addr] <= commit_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else if (issue_valid) begin
            wr_valid <= 1'b1;
        end else if (written) begin
            wr_valid <= 1'b0;
        end
    end

    // Target holds the address until the store commits
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result <= '{issue_instr.tag, value, 1'b0, DATA_WIDTH'(addr)};
        end
    end

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH  = core_pkg::ROB_DEPTH,
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            enable,
    input  wire core_pkg::op_t             op,
    input  wire core_pkg::result_t         alu_result,
    input  wire                            alu_wr_valid,
    input  wire core_pkg::result_t         lb_result,
    input  wire                            lb_wr_valid,
    output logic                           full,
    output logic [core_pkg::TAG_WIDTH-1:0] tail_tag,
    output logic [core_pkg::TAG_WIDTH-1:0] head_tag,
    output logic                           alu_wr_written,
    output logic                           lb_wr_written,
    output logic                           commit_valid,
    output core_pkg::commit_t              commit,
    output logic                           commit_wr_mem,
    output logic                           redirect_valid,
    output logic [DATA_WIDTH-1:0]          redirect_target
);
    import core_pkg::*;

    localparam int CNT_WIDTH = $clog2(ROB_DEPTH + 1);

    op_t                   op_q    [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  done_q;
    logic [CNT_WIDTH-1:0]  count;
    result_t               bus;
    logic                  bus_valid;

    // ==============================
    // Result bus, ALU first
    // ==============================
    assign alu_wr_written = alu_wr_valid;
    assign lb_wr_written  = lb_wr_valid & ~alu_wr_valid;
    assign bus_valid      = alu_wr_valid | lb_wr_valid;
    assign bus            = alu_wr_valid ? alu_result : lb_result;

    assign redirect_valid  = alu_wr_valid & alu_result.taken;
    assign redirect_target = alu_result.target;

    assign full          = (count == CNT_WIDTH'(ROB_DEPTH));
    assign commit_valid  = done_q[head_tag];
    assign commit_wr_mem = commit_valid & (op_q[head_tag] == STORE);
    assign commit        = '{head_tag, op_q[head_tag], value_q[head_tag]};

    always_ff @(posedge clock) begin
        if (enable) begin
            op_q[tail_tag] <= op;
        end
        if (bus_valid) begin
            value_q[bus.tag] <= bus.value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q   <= '0;
            head_tag <= '0;
            tail_tag <= '0;
            count    <= '0;
        end else begin
            if (enable) begin
                done_q[tail_tag] <= 1'b0;
                tail_tag         <= tail_tag + 1'b1;
            end
            if (bus_valid) begin
                done_q[bus.tag] <= 1'b1;
            end
            if (commit_valid) begin
                done_q[head_tag] <= 1'b0;
                head_tag         <= head_tag + 1'b1;
            end
            case ({enable, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/reservation_station.sv ====
`default_nettype none

module reservation_station #(
    parameter int DEPTH      = 4,
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    input  wire                           clock,
    input  wire                           reset,
    input  wire                           enable,
    input  wire core_pkg::instr_t         in_instr,
    input  wire                           exec_stall,
    input  wire                           head_only,
    input  wire [core_pkg::TAG_WIDTH-1:0] head_tag,
    output logic                          full,
    output logic                          issue_valid,
    output core_pkg::instr_t              issue_instr
);
    import core_pkg::*;

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    op_t                     op_q      [DEPTH];
    logic [3*DATA_WIDTH-1:0] payload_q [DEPTH];
    logic [TAG_WIDTH-1:0]    tag_q     [DEPTH];

    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [CNT_WIDTH-1:0] count;
    logic                 head_ready;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_WIDTH'(DEPTH));

    // Memory ops wait for the ROB head
    assign head_ready  = ~head_only | (tag_q[head] == head_tag);
    assign issue_valid = (count != '0) & ~exec_stall & head_ready;
    assign issue_instr = {op_q[head], payload_q[head], tag_q[head]};

    always_ff @(posedge clock) begin
        if (enable) begin
            op_q[tail]      <= in_instr.op;
            payload_q[tail] <= in_instr.payload;
            tag_q[tail]     <= in_instr.tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enable) begin
                tail <= next_ptr(tail);
            end
            if (issue_valid) begin
                head <= next_ptr(head);
            end
            case ({enable, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb/core_checker.sv ====
`default_nettype none

module core_checker (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            in_valid,
    input  wire                            in_ready,
    input  wire core_pkg::instr_t          in_instr,
    input  wire                            commit_valid,
    input  wire core_pkg::commit_t         commit,
    input  wire                            redirect_valid,
    input  wire [core_pkg::DATA_WIDTH-1:0] redirect_target,
    input  wire                            test_end,
    input  wire [8*16-1:0]                 test_name,
    output int                             outstanding,
    output int                             error_count,
    output int                             commit_count
);
    import core_pkg::*;

    commit_t               expect_q   [$];
    logic [DATA_WIDTH-1:0] redirect_q [$];
    logic [DATA_WIDTH-1:0] model_mem  [2**ADDR_WIDTH];
    logic [TAG_WIDTH-1:0]  next_tag;
    int                    errors;
    int                    commits;
    int                    test_errors;
    int                    test_commits;

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    always @(posedge clock) begin
        commit_t               exp_c;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] exp_target;
        if (reset) begin
            expect_q.delete();
            redirect_q.delete();
            for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
                model_mem[i] = '0;
            end
            next_tag     = '0;
            errors       = 0;
            commits      = 0;
            test_errors  = 0;
            test_commits = 0;
        end else begin
            // ==============================
            // Commit port
            // ==============================
            if (commit_valid) begin
                commits++;
                test_commits++;
                if (expect_q.size() == 0) begin
                    $display("%0s: commit of tag %0d with no instruction outstanding",
                             test_name, commit.tag);
                    count_error();
                end else begin
                    exp_c = expect_q.pop_front();
                    if (commit !== exp_c) begin
                        $write("MISMATCH %0s: expected tag %0d op %0d value %h, ",
                               test_name, exp_c.tag, exp_c.op, exp_c.value);
                        $display("actual tag %0d op %0d value %h",
                                 commit.tag, commit.op, commit.value);
                        count_error();
                    end
                end
            end

            if (redirect_valid) begin
                if (redirect_q.size() == 0) begin
                    $display("%0s: redirect to %h with no taken branch outstanding",
                             test_name, redirect_target);
                    count_error();
                end else begin
                    exp_target = redirect_q.pop_front();
                    if (redirect_target !== exp_target) begin
                        $display("MISMATCH %0s: redirect target expected %h actual %h",
                                 test_name, exp_target, redirect_target);
                        count_error();
                    end
                end
            end

            // ==============================
            // Sequential model
            // ==============================
            if (in_valid && in_ready) begin
                a         = in_instr.payload.alu.a;
                b         = in_instr.payload.alu.b;
                exp_c.tag = next_tag;
                exp_c.op  = in_instr.op;
                case (in_instr.op)
                    ADD:  exp_c.value = a + b;
                    SUB:  exp_c.value = a - b;
                    AND:  exp_c.value = a & b;
                    XOR:  exp_c.value = a ^ b;
                    BEQ:  exp_c.value = (a == b) ? DATA_WIDTH'(1) : '0;
                    LOAD: exp_c.value = model_mem[in_instr.payload.mem.addr];
                    default: begin
                        exp_c.value = in_instr.payload.mem.data;
                        model_mem[in_instr.payload.mem.addr] = in_instr.payload.mem.data;
                    end
                endcase
                if (in_instr.op == BEQ && a == b) begin
                    redirect_q.push_back(in_instr.payload.alu.target);
                end
                expect_q.push_back(exp_c);
                next_tag = next_tag + 1'b1;
            end

            if (test_end) begin
                if (redirect_q.size() != 0) begin
                    $display("%0s: %0d taken branches gave no redirect",
                             test_name, redirect_q.size());
                    count_error();
                    redirect_q.delete();
                end
                $display("%0s: %0d commits, %0d errors", test_name, test_commits, test_errors);
                test_commits = 0;
                test_errors  = 0;
            end
        end
        outstanding  <= expect_q.size();
        error_count  <= errors;
        commit_count <= commits;
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top;
    import core_pkg::*;

    localparam int SEND_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 1000;
    localparam int ALU_TEST    = 0;
    localparam int MEM_TEST    = 1;
    localparam int BRANCH_TEST = 2;
    localparam int MIXED_TEST  = 3;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    instr_t                in_instr;
    logic                  in_ready;
    logic                  commit_valid;
    commit_t               commit;
    logic                  redirect_valid;
    logic [DATA_WIDTH-1:0] redirect_target;
    logic                  test_end;
    logic [8*16-1:0]       test_name;
    int                    outstanding;
    int                    error_count;
    int                    commit_count;
    logic [31:0]           lfsr_state;
    logic                  timed_out;
    int                    test_count;

    dispatch_core #(
        .DATA_WIDTH (DATA_WIDTH),
        .ROB_DEPTH  (ROB_DEPTH),
        .RS_DEPTH   (4)
    ) dut (
        .clock, .reset, .in_valid, .in_instr, .in_ready,
        .commit_valid, .commit, .redirect_valid, .redirect_target
    );

    core_checker scoreboard (
        .clock, .reset, .in_valid, .in_ready, .in_instr,
        .commit_valid, .commit, .redirect_valid, .redirect_target,
        .test_end, .test_name, .outstanding, .error_count, .commit_count
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t next_instr(input int kind);
        logic [2:0] sel;
        instr_t     ins;
        case (kind)
            ALU_TEST:    sel = {1'b0, 2'(random_bits(2))};
            MEM_TEST:    sel = (random_bits(1) != 0) ? 3'(LOAD) : 3'(STORE);
            BRANCH_TEST: sel = (random_bits(1) != 0) ? 3'(BEQ) : {1'b0, 2'(random_bits(2))};
            default: begin
                sel = 3'(random_bits(3));
                if (sel == 3'd7) begin
                    sel = 3'(LOAD);
                end
            end
        endcase
        ins    = '0;
        ins.op = op_t'(sel);
        if (ins.op == LOAD || ins.op == STORE) begin
            ins.payload.mem.addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
            ins.payload.mem.data = DATA_WIDTH'(random_bits(DATA_WIDTH));
        end else begin
            ins.payload.alu.a      = DATA_WIDTH'(random_bits(DATA_WIDTH));
            // Equal operands half the time so branches go both ways
            ins.payload.alu.b      = (random_bits(1) != 0) ? ins.payload.alu.a
                                                           : DATA_WIDTH'(random_bits(DATA_WIDTH));
            ins.payload.alu.target = DATA_WIDTH'(random_bits(DATA_WIDTH));
        end
        return ins;
    endfunction

    // ==============================
    // Fetch-side driver
    // ==============================
    task automatic send_instr(input instr_t ins, input int gap);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_instr <= ins;
        @(posedge clock);
        while (!in_ready && !timed_out) begin
            waited++;
            if (waited > SEND_LIMIT) begin
                $display("timeout: instruction not accepted within %0d cycles", SEND_LIMIT);
                timed_out = 1'b1;
            end else begin
                @(posedge clock);
            end
        end
        in_valid <= 1'b0;
        repeat (gap) @(posedge clock);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (outstanding != 0 && waited < DRAIN_LIMIT);
        if (outstanding != 0) begin
            $display("timeout: %0d instructions still outstanding after %0d cycles",
                     outstanding, DRAIN_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input logic [8*16-1:0] name, input int kind, input int count,
                            input logic gaps);
        int gap;
        test_name <= name;
        for (int i = 0; i < count && !timed_out; i++) begin
            gap = gaps ? int'(random_bits(2)) : 0;
            send_instr(next_instr(kind), gap);
        end
        if (!timed_out) begin
            wait_drain();
        end
        if (!timed_out) begin
            test_end <= 1'b1;
            @(posedge clock);
            test_end <= 1'b0;
            test_count++;
        end
    endtask

    initial begin
        lfsr_state = 32'h2a25_c788;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        test_end   = 1'b0;
        test_name  = '0;
        timed_out  = 1'b0;
        test_count = 0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        run_test("alu_arith", ALU_TEST, 40, 1'b0);
        run_test("memory", MEM_TEST, 40, 1'b0);
        run_test("branch", BRANCH_TEST, 30, 1'b0);
        // No gaps, so the stations and the ROB fill up
        run_test("back_pressure", MIXED_TEST, 60, 1'b0);
        run_test("fetch_gaps", MIXED_TEST, 50, 1'b1);

        repeat (2) @(posedge clock);
        $display("tests %0d, commits %0d, errors %0d", test_count, commit_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire
